//--- Makefile
# Verilator flow for the usbBridge testbench
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_usbBridge
RTL_TOP   ?= usbBridge
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED
FAIL_MSG  ?= CHECKS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
verilog/usbBusPkg.sv
verilog/dumpPkg.sv
verilog/busMux.sv
verilog/sipoBuffer.sv
verilog/msgRom.sv
verilog/fifoTransmitter.sv
verilog/usbBridge.sv
verification/clockGen.sv
verification/tb_usbBridge.sv

//--- verification/clockGen.sv
module clockGen #(
    parameter int periodNs    = 10,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2.0) clk = ~clk;  // first rising edge at half a period
    end

    // held over the first rising edges, dropped on a falling edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- verification/tb_usbBridge.sv
module tb_usbBridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pageBytes    = 8;
    localparam int charsPerDump = 17 + 2 * pageBytes;  // title, page, sep, data, CR LF
    localparam int dumpCount    = 4;                   // boot, user, stalled, busy-ignore
    localparam int cycleLimit   = dumpCount * charsPerDump * 6 * 4 + 2000;

    logic                 MCLK;
    logic                 reset;
    logic                 nEN;
    logic                 PWRSTAT;
    logic                 nFIFOEN;
    logic                 nFIFOBUFWRCLKEN;
    dumpPkg::bitAddr_t    FIFOBUFWRADDR;
    logic                 FIFOBUFWRDATA;
    logic                 nFIFOSENDBOOT;
    logic                 nFIFOSENDUSER;
    dumpPkg::pageNum_t    FIFOCURRPAGE;
    logic                 MPSSECLK;
    logic                 MPSSEMOSI;
    logic                 MPSSEMISO;
    logic                 nMPSSECS;
    usbBusPkg::fifoByte_t adbusIn;
    usbBusPkg::fifoByte_t adbusOut;
    logic [7:0]           adbusOe;
    logic [5:0]           acbusIn;   // [5] nMPSSEON, [1] nTxe, [0] nRxf
    logic [5:0]           acbusOut;  // [3] is nWr
    logic [5:0]           acbusOe;
    logic                 dutBusy;

    logic [7:0]        refBytes [pageBytes];  // what the page buffer should hold
    logic [7:0]        expQ [$];              // characters the host still expects
    logic [7:0]        expChar;
    logic              modelArmed;
    dumpPkg::pageNum_t userPage;
    logic [31:0]       rngState;
    int                errorCount;
    int                testsRun;
    int                testsFailed;
    int                cycleCount;

    clockGen #(.periodNs(10), .resetCycles(4)) u_clockGen (.clk(MCLK), .reset(reset));

    usbBridge #(.pageBytes(pageBytes)) u_dut (
        .MCLK, .reset, .nEN, .PWRSTAT, .nFIFOEN, .nFIFOBUFWRCLKEN, .FIFOBUFWRADDR,
        .FIFOBUFWRDATA, .nFIFOSENDBOOT, .nFIFOSENDUSER, .FIFOCURRPAGE, .MPSSECLK,
        .MPSSEMOSI, .MPSSEMISO, .nMPSSECS, .adbusIn, .adbusOut, .adbusOe, .acbusIn,
        .acbusOut, .acbusOe
    );

    assign dutBusy = u_dut.u_fifoTransmitter.busy;  // no top-level port for it

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] hexDigit(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";  // upper case on the wire
        return digits[nib];
    endfunction

    task automatic reportMismatch(input string sigName, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("[FAIL] t=%0t ns %s = 0x%0h, expected 0x%0h", $time, sigName, got, want);
        errorCount++;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
            $display("test %-16s failed, %0d errors", name, errorCount - errorsBefore);
        end else begin
            $display("test %-16s ok", name);
        end
    endtask

    task automatic setMode(input logic enN, input logic pwr, input logic mpsseOnN);
        @(negedge MCLK);
        nEN        = enN;
        PWRSTAT    = pwr;
        acbusIn[5] = mpsseOnN;
    endtask

    // shift refBytes into the buffer one bit per cycle with bit 8n+k = byte n bit k
    task automatic loadPage();
        for (int b = 0; b < pageBytes * 8; b++) begin
            @(negedge MCLK);
            nFIFOEN         = 1'b0;
            nFIFOBUFWRCLKEN = 1'b0;
            FIFOBUFWRADDR   = dumpPkg::bitAddr_t'(b);
            FIFOBUFWRDATA   = refBytes[b / 8][b % 8];
        end
        @(negedge MCLK);
        nFIFOEN         = 1'b1;
        nFIFOBUFWRCLKEN = 1'b1;
    endtask

    task automatic sendRequest(input bit user, input dumpPkg::pageNum_t page);
        @(negedge MCLK);
        FIFOCURRPAGE = page;
        if (user) begin
            nFIFOSENDUSER = 1'b0;
        end else begin
            nFIFOSENDBOOT = 1'b0;
        end
        @(negedge MCLK);  // one-cycle low pulse
        nFIFOSENDUSER = 1'b1;
        nFIFOSENDBOOT = 1'b1;
    endtask

    // expected text line built straight from the stream format
    task automatic queueDump(input bit user, input dumpPkg::pageNum_t page);
        string title;
        title = user ? "USER PAGE " : "BOOT PAGE ";
        for (int i = 0; i < title.len(); i++) begin
            expQ.push_back(title[i]);
        end
        expQ.push_back(hexDigit(page[11:8]));
        expQ.push_back(hexDigit(page[7:4]));
        expQ.push_back(hexDigit(page[3:0]));
        expQ.push_back(":");
        expQ.push_back(" ");
        for (int n = 0; n < pageBytes; n++) begin
            expQ.push_back(hexDigit(refBytes[n][7:4]));  // high nibble first
            expQ.push_back(hexDigit(refBytes[n][3:0]));
        end
        expQ.push_back(8'h0d);
        expQ.push_back(8'h0a);
    endtask

    // runs until busy drops while optionally throttling nTxe at random
    task automatic waitDumpEnd(input bit stall);
        if (!dutBusy) begin
            $display("dump did not start at t=%0t ns", $time);
            errorCount++;
        end
        while (dutBusy) begin
            @(negedge MCLK);
            if (stall) begin
                rngState   = xorshift(rngState);
                acbusIn[1] = rngState[0];  // about half the cycles stalled
            end
        end
        acbusIn[1] = 1'b0;
        if (expQ.size() != 0) begin
            $display("dump ended with %0d characters never sent", expQ.size());
            errorCount++;
            expQ.delete();
        end
    endtask

    task automatic modeTable();
        int         errorsBefore;
        logic       fifoOn;
        logic       mpsseOn;
        logic [7:0] expOe;
        logic       expClk;
        logic       expMosi;
        logic       expCs;
        errorsBefore = errorCount;
        if (dutBusy !== 1'b0) reportMismatch("busy", 32'(dutBusy), 32'd0);
        if (adbusOut !== 8'h00) reportMismatch("adbusOut", 32'(adbusOut), 32'd0);
        for (int i = 0; i < 8; i++) begin
            rngState = xorshift(rngState);
            @(negedge MCLK);
            nEN        = i[2];
            PWRSTAT    = i[1];
            acbusIn[5] = i[0];
            adbusIn    = rngState[7:0];
            @(posedge MCLK);
            fifoOn  = !i[2] && !i[1] && i[0];   // mode 01
            mpsseOn = !i[2] && i[1] && !i[0];   // mode 10
            expOe   = fifoOn ? 8'hff : (mpsseOn ? 8'h04 : 8'h00);
            expClk  = mpsseOn ? adbusIn[0] : 1'b1;
            expMosi = mpsseOn ? adbusIn[1] : 1'b0;
            expCs   = mpsseOn ? adbusIn[3] : 1'b1;
            if (adbusOe !== expOe) reportMismatch("adbusOe", 32'(adbusOe), 32'(expOe));
            if (acbusOut !== 6'b011100) reportMismatch("acbusOut", 32'(acbusOut), 32'h1c);
            if (acbusOe !== 6'b011100) reportMismatch("acbusOe", 32'(acbusOe), 32'h1c);
            if (MPSSECLK !== expClk) reportMismatch("MPSSECLK", 32'(MPSSECLK), 32'(expClk));
            if (MPSSEMOSI !== expMosi) reportMismatch("MPSSEMOSI", 32'(MPSSEMOSI), 32'(expMosi));
            if (nMPSSECS !== expCs) reportMismatch("nMPSSECS", 32'(nMPSSECS), 32'(expCs));
        end
        setMode(1'b0, 1'b0, 1'b1);
        adbusIn = '0;
        finishTest("modeTable", errorsBefore);
    endtask

    task automatic mpssePassThrough();
        int errorsBefore;
        errorsBefore = errorCount;
        setMode(1'b0, 1'b1, 1'b0);
        for (int i = 0; i < 16; i++) begin
            rngState = xorshift(rngState);
            @(negedge MCLK);
            adbusIn   = rngState[7:0];
            MPSSEMISO = rngState[8];
            @(posedge MCLK);
            if (MPSSECLK !== adbusIn[0]) begin
                reportMismatch("MPSSECLK", 32'(MPSSECLK), 32'(adbusIn[0]));
            end
            if (MPSSEMOSI !== adbusIn[1]) begin
                reportMismatch("MPSSEMOSI", 32'(MPSSEMOSI), 32'(adbusIn[1]));
            end
            if (nMPSSECS !== adbusIn[3]) begin
                reportMismatch("nMPSSECS", 32'(nMPSSECS), 32'(adbusIn[3]));
            end
            if (adbusOut[2] !== MPSSEMISO) begin
                reportMismatch("adbusOut[2]", 32'(adbusOut[2]), 32'(MPSSEMISO));
            end
            if (adbusOe !== 8'h04) reportMismatch("adbusOe", 32'(adbusOe), 32'h04);
        end
        setMode(1'b0, 1'b0, 1'b1);
        adbusIn   = '0;
        MPSSEMISO = 1'b0;
        finishTest("mpssePassThrough", errorsBefore);
    endtask

    task automatic bootDump();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int n = 0; n < pageBytes; n++) begin
            refBytes[n] = 8'(8'h01 + 8'h22 * n);  // 01 23 45 .. EF uses every digit once
        end
        loadPage();
        queueDump(1'b0, 12'ha5c);
        sendRequest(1'b0, 12'ha5c);
        waitDumpEnd(1'b0);
        finishTest("bootDump", errorsBefore);
    endtask

    task automatic userDumpRandom();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int n = 0; n < pageBytes; n++) begin
            rngState    = xorshift(rngState);
            refBytes[n] = rngState[7:0];
        end
        rngState = xorshift(rngState);
        userPage = rngState[11:0];
        loadPage();
        queueDump(1'b1, userPage);
        sendRequest(1'b1, userPage);
        waitDumpEnd(1'b0);
        finishTest("userDumpRandom", errorsBefore);
    endtask

    // same page as the unstalled user dump so the same text must come out
    task automatic backPressure();
        int errorsBefore;
        errorsBefore = errorCount;
        queueDump(1'b1, userPage);
        sendRequest(1'b1, userPage);
        waitDumpEnd(1'b1);
        finishTest("backPressure", errorsBefore);
    endtask

    task automatic ignoredRequests();
        int errorsBefore;
        errorsBefore = errorCount;
        setMode(1'b1, 1'b0, 1'b1);  // fifo mode but globally disabled
        sendRequest(1'b0, 12'h123);
        repeat (40) @(negedge MCLK);
        if (dutBusy !== 1'b0) reportMismatch("busy", 32'(dutBusy), 32'd0);
        setMode(1'b0, 1'b1, 1'b0);  // flash owns the bus
        sendRequest(1'b1, 12'h456);
        repeat (40) @(negedge MCLK);
        if (dutBusy !== 1'b0) reportMismatch("busy", 32'(dutBusy), 32'd0);
        setMode(1'b0, 1'b0, 1'b1);
        queueDump(1'b0, 12'h3c7);
        sendRequest(1'b0, 12'h3c7);
        repeat (20) @(negedge MCLK);
        sendRequest(1'b1, 12'hfff);  // mid-dump request must not disturb the line
        repeat (30) @(negedge MCLK);
        sendRequest(1'b0, 12'h000);
        waitDumpEnd(1'b0);
        repeat (20) @(negedge MCLK);
        if (dutBusy !== 1'b0) begin
            $display("a request made while busy started another dump");
            errorCount++;
        end
        finishTest("ignoredRequests", errorsBefore);
    endtask

    // host side of the FT232H takes the byte on the nWr rising edge
    always @(posedge acbusOut[3]) begin
        if (modelArmed) begin
            if (expQ.size() == 0) begin
                $display("unexpected nWr strobe at t=%0t ns carrying 0x%0h", $time, adbusOut);
                errorCount++;
            end else begin
                expChar = expQ.pop_front();
                if (adbusOut !== expChar) reportMismatch("adbusOut", 32'(adbusOut), 32'(expChar));
            end
        end
    end

    always @(negedge acbusOut[3]) begin
        if (modelArmed && acbusIn[1] !== 1'b0) begin
            $display("nWr fell at t=%0t ns while nTxe was high", $time);
            errorCount++;
        end
    end

    always @(posedge MCLK) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout, run stopped after %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        errorCount      = 0;
        testsRun        = 0;
        testsFailed     = 0;
        cycleCount      = 0;
        modelArmed      = 1'b0;
        rngState        = 32'hfcc622fd;
        userPage        = '0;
        nEN             = 1'b0;
        PWRSTAT         = 1'b0;
        acbusIn         = 6'b100001;  // fifo mode with TXE room and nothing to read
        adbusIn         = '0;
        MPSSEMISO       = 1'b0;
        nFIFOEN         = 1'b1;
        nFIFOBUFWRCLKEN = 1'b1;
        FIFOBUFWRADDR   = '0;
        FIFOBUFWRDATA   = 1'b0;
        nFIFOSENDBOOT   = 1'b1;
        nFIFOSENDUSER   = 1'b1;
        FIFOCURRPAGE    = '0;
        @(negedge reset);
        modelArmed = 1'b1;  // X to 1 on nWr at startup is not a byte
        modeTable();
        mpssePassThrough();
        bootDump();
        userDumpRandom();
        backPressure();
        ignoredRequests();
        $display("summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/busMux.sv
module busMux (
    input  logic                    MCLK,       // assertions only
    input  logic                    reset,
    input  logic                    nEN,        // global disable from the core
    input  logic                    PWRSTAT,
    input  usbBusPkg::fifoByte_t    adbusIn,
    input  logic [5:0]              acbusIn,
    input  logic                    MPSSEMISO,
    input  usbBusPkg::fifoByte_t    txData,
    input  usbBusPkg::ft245Ctrl_t   txCtrl,
    output usbBusPkg::fifoByte_t    adbusOut,
    output logic [7:0]              adbusOe,
    output logic [5:0]              acbusOut,
    output logic [5:0]              acbusOe,
    output logic                    MPSSECLK,
    output logic                    MPSSEMOSI,
    output logic                    nMPSSECS,
    output logic                    fifoEnable,
    output usbBusPkg::ft245Status_t txStatus
);

    usbBusPkg::busMode_e   mode;
    logic                  mpsseEnable;
    usbBusPkg::ft245Ctrl_t ctrlPins;

    assign mode = usbBusPkg::busMode_e'({PWRSTAT, acbusIn[5]}); // ACBUS5 = nMPSSEON

    // path select with at most one owner
    always_comb begin
        fifoEnable  = 1'b0;
        mpsseEnable = 1'b0;
        if (!nEN) begin
            case (mode)
                usbBusPkg::modeFifo:  fifoEnable  = 1'b1;
                usbBusPkg::modeMpsse: mpsseEnable = 1'b1;
                default: ; // illegal and standby leave both off
            endcase
        end
    end

    // flash side parks with clk and cs high so no stray access
    assign MPSSECLK  = mpsseEnable ? adbusIn[0] : 1'b1;
    assign MPSSEMOSI = mpsseEnable ? adbusIn[1] : 1'b0;
    assign nMPSSECS  = mpsseEnable ? adbusIn[3] : 1'b1;

    // ADBUS drivers
    always_comb begin
        adbusOut = '0;
        adbusOe  = '0;
        if (fifoEnable) begin
            adbusOut = txData;         // whole byte is ours
            adbusOe  = 8'hff;
        end else if (mpsseEnable) begin
            adbusOut[2] = MPSSEMISO;   // only miso flows back to the chip
            adbusOe[2]  = 1'b1;
        end
    end

    // strobes idle high when fifo is off like the board pull-ups
    assign ctrlPins = fifoEnable ? txCtrl : '1;
    assign acbusOut = {1'b0, ctrlPins, 2'b00};
    assign acbusOe  = 6'b01_1100;                              // only ACBUS[4:2] driven
    assign txStatus = usbBusPkg::ft245Status_t'(acbusIn[1:0]);

    // flash pins stay parked whenever the fifo side owns ADBUS
    pathsExclusive: assert property (@(posedge MCLK) disable iff (reset)
        (adbusOe == 8'hff) |-> (MPSSECLK && !MPSSEMOSI && nMPSSECS))
        else $error("fifo and mpsse paths enabled together");

    // ADBUS2 only driven in stable fifo or mpsse mode with nEN low
    misoOnlyWhenOwned: assert property (@(posedge MCLK) disable iff (reset)
        adbusOe[2] |-> (!nEN && (PWRSTAT != acbusIn[5])))
        else $error("ADBUS2 driven with both paths off");

endmodule

//--- verilog/dumpPkg.sv
package dumpPkg;

    typedef logic [12:0] bitAddr_t;   // 8k x 1 page buffer, write side
    typedef logic [9:0]  byteAddr_t;  // 1k x 8, read side
    typedef logic [11:0] pageNum_t;   // bubble page number
    typedef logic [6:0]  textAddr_t;  // message rom
    typedef logic [7:0]  asciiChar_t;

    // title strings held in msgRom
    localparam textAddr_t bootTitleAddr = 7'd0;  // "BOOT PAGE "
    localparam int        bootTitleLen  = 10;
    localparam textAddr_t userTitleAddr = 7'd16; // "USER PAGE "
    localparam int        userTitleLen  = 10;

    // per-character steps of the transmitter
    // data goes onto ADBUS before the TXE wait, so nWr drops straight out of stWait
    typedef enum logic [2:0] {
        stIdle,    // no dump running
        stFetch,   // rom or page buffer read cycle
        stPlace,   // character latched onto the data lines
        stWait,    // hold here until TXE low and fifo path enabled
        stStrobe,  // nWr low, first cycle
        stHold,    // nWr low, second cycle
        stRelease  // nWr back high, step the counters
    } txState_e;

endpackage

//--- verilog/fifoTransmitter.sv
module fifoTransmitter #(
    parameter int pageBytes = 64  // data bytes per dump, 1..1024
) (
    input  logic                    MCLK,
    input  logic                    reset,
    input  logic                    fifoEnable,
    input  usbBusPkg::ft245Status_t txStatus,
    input  logic                    nFIFOSENDBOOT,
    input  logic                    nFIFOSENDUSER,
    input  dumpPkg::pageNum_t       FIFOCURRPAGE,
    input  dumpPkg::asciiChar_t     romData,
    input  usbBusPkg::fifoByte_t    bufData,
    output logic                    romEn,
    output dumpPkg::textAddr_t      romAddr,
    output logic                    bufEn,
    output dumpPkg::byteAddr_t      bufAddr,
    output usbBusPkg::fifoByte_t    txData,
    output usbBusPkg::ft245Ctrl_t   txCtrl,
    output logic                    busy
);

    // which part of the line is going out
    typedef enum logic [2:0] {
        phTitle,  // rom string
        phPage,   // 3 hex digits
        phSep,    // ": "
        phData,   // 2 hex digits per byte
        phEol     // CR LF
    } txPhase_e;

    dumpPkg::txState_e   state;
    dumpPkg::txState_e   stateNext;
    txPhase_e            phase;
    logic [11:0]         loopCnt;    // chars left in this phase
    dumpPkg::pageNum_t   pageLatch;
    logic                nibbleHi;   // high nibble of bufData goes next
    logic                nWr;
    logic                bootPrev;
    logic                userPrev;
    logic                bootFall;
    logic                userFall;
    logic                userReq;
    logic                startReq;
    logic                txReady;
    logic                lastChar;
    logic [3:0]          pageNibble;
    dumpPkg::asciiChar_t nextChar;

    function automatic dumpPkg::asciiChar_t hexAscii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};  // '0'..'9'
        end
        return 8'h37 + {4'h0, nib};      // 'A'..'F'
    endfunction

    // request edges, boot wins a tie
    assign bootFall = bootPrev && !nFIFOSENDBOOT;
    assign userFall = userPrev && !nFIFOSENDUSER;
    assign userReq  = userFall && !bootFall;
    assign startReq = (bootFall || userFall) && fifoEnable;

    assign txReady  = !txStatus.nTxe && fifoEnable;
    assign lastChar = (phase == phEol) && (loopCnt == 12'd1);

    assign romEn = (state == dumpPkg::stFetch) && (phase == phTitle);
    assign bufEn = (state == dumpPkg::stFetch) && (phase == phData);

    always_comb begin
        case (loopCnt[1:0])
            2'd3:    pageNibble = pageLatch[11:8];  // high digit first
            2'd2:    pageNibble = pageLatch[7:4];
            default: pageNibble = pageLatch[3:0];
        endcase
    end

    // character for the current slot, rom/buffer data valid in stPlace
    always_comb begin
        case (phase)
            phTitle: nextChar = romData;
            phPage:  nextChar = hexAscii(pageNibble);
            phSep:   nextChar = (loopCnt == 12'd2) ? ":" : " ";
            phData:  nextChar = hexAscii(nibbleHi ? bufData[7:4] : bufData[3:0]);
            default: nextChar = (loopCnt == 12'd2) ? 8'h0d : 8'h0a;
        endcase
    end

    always_comb begin
        stateNext = state;
        case (state)
            dumpPkg::stIdle:    if (startReq) stateNext = dumpPkg::stFetch;
            dumpPkg::stFetch:   stateNext = dumpPkg::stPlace;
            dumpPkg::stPlace:   stateNext = dumpPkg::stWait;
            dumpPkg::stWait:    if (txReady) stateNext = dumpPkg::stStrobe; // back-pressure
            dumpPkg::stStrobe:  stateNext = dumpPkg::stHold;
            dumpPkg::stHold:    stateNext = dumpPkg::stRelease;
            dumpPkg::stRelease: stateNext = lastChar ? dumpPkg::stIdle : dumpPkg::stFetch;
            default:            stateNext = dumpPkg::stIdle;
        endcase
    end

    // control side
    always_ff @(posedge MCLK) begin
        if (reset) begin
            state    <= dumpPkg::stIdle;
            phase    <= phTitle;
            loopCnt  <= '0;
            busy     <= 1'b0;
            nWr      <= 1'b1;
            txData   <= '0;
            bootPrev <= 1'b1;
            userPrev <= 1'b1;
        end else begin
            state    <= stateNext;
            nWr      <= !(stateNext == dumpPkg::stStrobe || stateNext == dumpPkg::stHold);
            bootPrev <= nFIFOSENDBOOT;
            userPrev <= nFIFOSENDUSER;
            if (state == dumpPkg::stPlace) begin
                txData <= nextChar;
            end
            case (state)
                dumpPkg::stIdle: begin
                    if (startReq) begin
                        phase   <= phTitle;
                        loopCnt <= userReq ? 12'(dumpPkg::userTitleLen)
                                           : 12'(dumpPkg::bootTitleLen);
                        busy    <= 1'b1;
                    end
                end
                dumpPkg::stRelease: begin
                    if (loopCnt == 12'd1) begin
                        case (phase)   // next phase and its length
                            phTitle: begin
                                phase   <= phPage;
                                loopCnt <= 12'd3;
                            end
                            phPage: begin
                                phase   <= phSep;
                                loopCnt <= 12'd2;
                            end
                            phSep: begin
                                phase   <= phData;
                                loopCnt <= 12'(2 * pageBytes);
                            end
                            phData: begin
                                phase   <= phEol;
                                loopCnt <= 12'd2;
                            end
                            default: busy <= 1'b0;  // LF out, dump done
                        endcase
                    end else begin
                        loopCnt <= loopCnt - 12'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    // address / payload side
    always_ff @(posedge MCLK) begin
        if (state == dumpPkg::stIdle && startReq) begin
            pageLatch <= FIFOCURRPAGE;
            romAddr   <= userReq ? dumpPkg::userTitleAddr : dumpPkg::bootTitleAddr;
        end
        if (state == dumpPkg::stRelease) begin
            romAddr <= romAddr + 7'd1;  // only read in the title phase
            if (phase == phSep) begin
                bufAddr  <= '0;         // byte 0 first
                nibbleHi <= 1'b1;
            end else if (phase == phData) begin
                nibbleHi <= !nibbleHi;
                if (!nibbleHi) begin
                    bufAddr <= bufAddr + 10'd1;  // low nibble done, next byte
                end
            end
        end
    end

    // no host reads, no send-immediate
    always_comb begin
        txCtrl     = '1;
        txCtrl.nWr = nWr;
    end

    nWrFromWait: assert property (@(posedge MCLK) disable iff (reset)
        $fell(nWr) |-> $past(state) == dumpPkg::stWait && !$past(txStatus.nTxe)
                       && $past(fifoEnable))
        else $error("nWr fell without a TXE grant");

    idleNotBusy: assert property (@(posedge MCLK) disable iff (reset)
        state == dumpPkg::stIdle |-> !busy)
        else $error("busy high while transmitter idle");

endmodule

//--- verilog/msgRom.sv
module msgRom (
    input  logic                MCLK,
    input  logic                rdEn,
    input  dumpPkg::textAddr_t  addr,
    output dumpPkg::asciiChar_t data
);

    dumpPkg::asciiChar_t romChar;

    always_comb begin
        case (addr)
            dumpPkg::bootTitleAddr + 7'd0: romChar = "B";
            dumpPkg::bootTitleAddr + 7'd1: romChar = "O";
            dumpPkg::bootTitleAddr + 7'd2: romChar = "O";
            dumpPkg::bootTitleAddr + 7'd3: romChar = "T";
            dumpPkg::bootTitleAddr + 7'd4: romChar = " ";
            dumpPkg::bootTitleAddr + 7'd5: romChar = "P";
            dumpPkg::bootTitleAddr + 7'd6: romChar = "A";
            dumpPkg::bootTitleAddr + 7'd7: romChar = "G";
            dumpPkg::bootTitleAddr + 7'd8: romChar = "E";
            dumpPkg::bootTitleAddr + 7'd9: romChar = " ";  // gap before page number
            dumpPkg::userTitleAddr + 7'd0: romChar = "U";
            dumpPkg::userTitleAddr + 7'd1: romChar = "S";
            dumpPkg::userTitleAddr + 7'd2: romChar = "E";
            dumpPkg::userTitleAddr + 7'd3: romChar = "R";
            dumpPkg::userTitleAddr + 7'd4: romChar = " ";
            dumpPkg::userTitleAddr + 7'd5: romChar = "P";
            dumpPkg::userTitleAddr + 7'd6: romChar = "A";
            dumpPkg::userTitleAddr + 7'd7: romChar = "G";
            dumpPkg::userTitleAddr + 7'd8: romChar = "E";
            dumpPkg::userTitleAddr + 7'd9: romChar = " ";
            default:                       romChar = " ";  // unused slots read as space
        endcase
    end

    // registered read, same latency as the page buffer
    always_ff @(posedge MCLK) begin
        if (rdEn) begin
            data <= romChar;
        end
    end

endmodule

//--- verilog/sipoBuffer.sv
module sipoBuffer (
    input  logic                 MCLK,
    input  logic                 nWrEn,      // buffer enable, active low
    input  logic                 wrClkEn_n,  // per-bit write strobe, active low
    input  dumpPkg::bitAddr_t    wrAddr,
    input  logic                 wrData,
    input  logic                 rdEn,
    input  dumpPkg::byteAddr_t   rdAddr,
    output usbBusPkg::fifoByte_t rdData
);

    usbBusPkg::fifoByte_t mem [1024];  // byte n holds bits 8n..8n+7

    logic               wrStrobe;
    dumpPkg::byteAddr_t wrByte;
    logic [2:0]         wrBit;

    assign wrStrobe = !nWrEn && !wrClkEn_n;
    assign wrByte   = wrAddr[12:3];
    assign wrBit    = wrAddr[2:0];     // bit 0 = lsb of the byte

    // serial side, one bit per strobe
    always_ff @(posedge MCLK) begin
        if (wrStrobe) begin
            mem[wrByte][wrBit] <= wrData;
        end
    end

    // parallel side, data valid the cycle after rdEn
    always_ff @(posedge MCLK) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

    wrAddrKnown: assert property (@(posedge MCLK)
        wrStrobe |-> !$isunknown(wrAddr))
        else $error("page buffer write with unknown address");

endmodule

//--- verilog/usbBridge.sv
module usbBridge #(
    parameter int pageBytes = 64
) (
    input  logic                    MCLK,
    input  logic                    reset,
    input  logic                    nEN,
    input  logic                    PWRSTAT,
    input  logic                    nFIFOEN,
    input  logic                    nFIFOBUFWRCLKEN,
    input  dumpPkg::bitAddr_t       FIFOBUFWRADDR,
    input  logic                    FIFOBUFWRDATA,
    input  logic                    nFIFOSENDBOOT,
    input  logic                    nFIFOSENDUSER,
    input  dumpPkg::pageNum_t       FIFOCURRPAGE,
    output logic                    MPSSECLK,
    output logic                    MPSSEMOSI,
    input  logic                    MPSSEMISO,
    output logic                    nMPSSECS,
    input  usbBusPkg::fifoByte_t    adbusIn,     // pad ring sits outside
    output usbBusPkg::fifoByte_t    adbusOut,
    output logic [7:0]              adbusOe,
    input  logic [5:0]              acbusIn,
    output logic [5:0]              acbusOut,
    output logic [5:0]              acbusOe
);

    usbBusPkg::fifoByte_t    txData;
    usbBusPkg::ft245Ctrl_t   txCtrl;
    usbBusPkg::ft245Status_t txStatus;
    logic                    fifoEnable;
    logic                    romEn;
    dumpPkg::textAddr_t      romAddr;
    dumpPkg::asciiChar_t     romData;
    logic                    bufEn;
    dumpPkg::byteAddr_t      bufAddr;
    usbBusPkg::fifoByte_t    bufData;

    busMux u_busMux (
        .MCLK, .reset, .nEN, .PWRSTAT, .adbusIn, .acbusIn, .MPSSEMISO,
        .txData, .txCtrl, .adbusOut, .adbusOe, .acbusOut, .acbusOe,
        .MPSSECLK, .MPSSEMOSI, .nMPSSECS, .fifoEnable, .txStatus
    );

    sipoBuffer u_sipoBuffer (
        .MCLK,
        .nWrEn     (nFIFOEN),
        .wrClkEn_n (nFIFOBUFWRCLKEN),
        .wrAddr    (FIFOBUFWRADDR),
        .wrData    (FIFOBUFWRDATA),
        .rdEn      (bufEn),
        .rdAddr    (bufAddr),
        .rdData    (bufData)
    );

    msgRom u_msgRom (.MCLK, .rdEn(romEn), .addr(romAddr), .data(romData));

    fifoTransmitter #(.pageBytes(pageBytes)) u_fifoTransmitter (
        .MCLK, .reset, .fifoEnable, .txStatus, .nFIFOSENDBOOT, .nFIFOSENDUSER,
        .FIFOCURRPAGE, .romData, .bufData, .romEn, .romAddr, .bufEn, .bufAddr,
        .txData, .txCtrl, .busy()  // busy is for the testbench probe and assertions
    );

endmodule

//--- verilog/usbBusPkg.sv
package usbBusPkg;

    // bus owner as seen on {PWRSTAT, nMPSSEON}
    typedef enum logic [1:0] {
        modeIllegal = 2'b00, // mpsse asked for while fifo still owns the pins
        modeFifo    = 2'b01, // stable fifo
        modeMpsse   = 2'b10, // stable mpsse, host talks to the flash
        modeStandby = 2'b11  // host has not reconfigured the chip yet
    } busMode_e;

    // ACBUS[1:0], msb first so a plain cast of the pins lines up
    typedef struct packed {
        logic nTxe; // ACBUS1, low = tx fifo has room
        logic nRxf; // ACBUS0, host data waiting (not read here)
    } ft245Status_t;

    // ACBUS[4:2]
    typedef struct packed {
        logic nSiwu; // ACBUS4
        logic nWr;   // ACBUS3, chip takes the byte on the rising edge
        logic nRd;   // ACBUS2
    } ft245Ctrl_t;

    typedef logic [7:0] fifoByte_t; // ADBUS data word

endpackage
